/* rtl/axil_byte_master.sv */
`timescale 1ns/1ps

module axil_byte_master (
	input  logic               clk,
	input  logic               rst,
	input  logic               bus_req,
	input  logic               bus_write,
	input  dbg_pkg::addr_t     bus_addr,
	input  uart_pkg::byte_t    bus_wdata,
	output logic               bus_done,
	output logic               bus_err,
	output uart_pkg::byte_t    bus_rdata,
	output dbg_pkg::addr_t     awaddr,
	output logic               awvalid,
	input  logic               awready,
	output dbg_pkg::axi_data_t wdata,
	output dbg_pkg::axi_strb_t wstrb,
	output logic               wvalid,
	input  logic               wready,
	input  dbg_pkg::axi_resp_t bresp,
	input  logic               bvalid,
	output logic               bready,
	output dbg_pkg::addr_t     araddr,
	output logic               arvalid,
	input  logic               arready,
	input  dbg_pkg::axi_data_t rdata,
	input  dbg_pkg::axi_resp_t rresp,
	input  logic               rvalid,
	output logic               rready
);

	dbg_pkg::addr_t addr_q;
	uart_pkg::byte_t wbyte_q;
	logic aw_ok;
	logic w_ok;

	assign awaddr = addr_q;
	assign araddr = addr_q;
	// Byte copied to every lane, strobe picks the one that counts
	assign wdata = {4{wbyte_q}};
	assign wstrb = dbg_pkg::axi_strb_t'(4'b0001 << addr_q[1:0]);

	// Channel finished or finishing this cycle
	assign aw_ok = !awvalid || awready;
	assign w_ok  = !wvalid || wready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			awvalid  <= 1'b0;
			wvalid   <= 1'b0;
			bready   <= 1'b0;
			arvalid  <= 1'b0;
			rready   <= 1'b0;
			bus_done <= 1'b0;
		end else begin
			bus_done <= 1'b0;
			if (bus_req) begin
				awvalid <= bus_write;
				wvalid  <= bus_write;
				arvalid <= !bus_write;
			end
			if (awvalid && awready)
				awvalid <= 1'b0;
			if (wvalid && wready)
				wvalid <= 1'b0;
			// Response phase opens once both address and data are taken
			if ((awvalid || wvalid) && aw_ok && w_ok)
				bready <= 1'b1;
			if (bready && bvalid) begin
				bready   <= 1'b0;
				bus_done <= 1'b1;
			end
			if (arvalid && arready) begin
				arvalid <= 1'b0;
				rready  <= 1'b1;
			end
			if (rready && rvalid) begin
				rready   <= 1'b0;
				bus_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus_req) begin
			addr_q  <= bus_addr;
			wbyte_q <= bus_wdata;
		end
		// SLVERR and DECERR both fail the access
		if (bready && bvalid)
			bus_err <= (bresp != dbg_pkg::resp_okay);
		if (rready && rvalid) begin
			bus_err   <= (rresp != dbg_pkg::resp_okay);
			bus_rdata <= rdata[{addr_q[1:0], 3'b000} +: 8];
		end
	end

	a_aw_hold: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid);

endmodule

/* rtl/dbg_cmd_seq.sv */
`timescale 1ns/1ps

module dbg_cmd_seq (
	input  logic            clk,
	input  logic            rst,
	input  logic            rx_valid,
	input  uart_pkg::byte_t rx_byte,
	output logic            tx_push,
	output uart_pkg::byte_t tx_byte,
	input  logic            tx_full,
	output logic            bus_req,
	output logic            bus_write,
	output dbg_pkg::addr_t  bus_addr,
	output uart_pkg::byte_t bus_wdata,
	input  logic            bus_done,
	input  logic            bus_err,
	input  uart_pkg::byte_t bus_rdata,
	output logic            cpu_halt,
	output logic            cpu_rst,
	input  logic            cpu_is_halted,
	output logic            bus_grant,
	output dbg_pkg::addr_t  pc_reset
);

	dbg_pkg::seq_state_t state;
	dbg_pkg::rst_cnt_t rst_cnt;
	dbg_pkg::addr_t addr_q;
	uart_pkg::byte_t wdata_q;
	uart_pkg::byte_t rdata_q;
	logic write_q;
	logic reply_nak;
	logic read_reply;
	logic data_phase;

	// Bus is safe with a confirmed halt or while the CPU sits in reset
	assign bus_grant = (cpu_halt && cpu_is_halted) || !cpu_rst;

	assign bus_write = write_q;
	assign bus_addr  = addr_q;
	assign bus_wdata = wdata_q;

	// Status first, then read data on a successful read
	assign tx_push = (state == dbg_pkg::seq_reply) && !tx_full;
	assign tx_byte = reply_nak ? dbg_pkg::nak_code :
	                 data_phase ? rdata_q : dbg_pkg::ack_code;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state      <= dbg_pkg::seq_idle;
			rst_cnt    <= '0;
			bus_req    <= 1'b0;
			cpu_halt   <= 1'b0;
			cpu_rst    <= 1'b1;
			pc_reset   <= '0;
			reply_nak  <= 1'b0;
			read_reply <= 1'b0;
			data_phase <= 1'b0;
		end else begin
			bus_req <= 1'b0;
			case (state)
				dbg_pkg::seq_idle: begin
					rst_cnt <= '0;
					if (rx_valid) begin
						reply_nak <= 1'b0;
						case (rx_byte)
							dbg_pkg::cmd_halt: begin
								cpu_halt <= 1'b1;
								state    <= dbg_pkg::seq_reply;
							end
							dbg_pkg::cmd_resume: begin
								cpu_halt <= 1'b0;
								state    <= dbg_pkg::seq_reply;
							end
							dbg_pkg::cmd_write_byte,
							dbg_pkg::cmd_read_byte: state <= dbg_pkg::seq_addr_hi;
							dbg_pkg::cmd_pulse_reset: begin
								cpu_rst <= 1'b0;
								state   <= dbg_pkg::seq_rst_count;
							end
							dbg_pkg::cmd_ping: state <= dbg_pkg::seq_reply;
							dbg_pkg::cmd_hold_reset: begin
								cpu_rst <= 1'b0;
								state   <= dbg_pkg::seq_reply;
							end
							dbg_pkg::cmd_release_reset: begin
								cpu_rst <= 1'b1;
								state   <= dbg_pkg::seq_reply;
							end
							// Unknown bytes are ignored
							default: state <= dbg_pkg::seq_idle;
						endcase
					end
				end
				dbg_pkg::seq_addr_hi: begin
					if (rx_valid)
						state <= dbg_pkg::seq_addr_lo;
				end
				dbg_pkg::seq_addr_lo: begin
					if (rx_valid) begin
						if (write_q) begin
							state <= dbg_pkg::seq_wdata;
						end else if (bus_grant) begin
							bus_req <= 1'b1;
							state   <= dbg_pkg::seq_bus_wait;
						end else begin
							reply_nak <= 1'b1;
							state     <= dbg_pkg::seq_reply;
						end
					end
				end
				dbg_pkg::seq_wdata: begin
					if (rx_valid) begin
						if (bus_grant) begin
							bus_req <= 1'b1;
							state   <= dbg_pkg::seq_bus_wait;
						end else begin
							reply_nak <= 1'b1;
							state     <= dbg_pkg::seq_reply;
						end
					end
				end
				dbg_pkg::seq_bus_wait: begin
					// Host bytes arriving here are dropped
					if (bus_done) begin
						reply_nak  <= bus_err;
						read_reply <= !bus_err && !write_q;
						state      <= dbg_pkg::seq_reply;
						// Reset vector tracks writes to its two addresses
						if (!bus_err && write_q && addr_q == dbg_pkg::vec_lo_addr)
							pc_reset[7:0] <= wdata_q;
						if (!bus_err && write_q && addr_q == dbg_pkg::vec_hi_addr)
							pc_reset[15:8] <= wdata_q;
					end
				end
				dbg_pkg::seq_rst_count: begin
					if (rst_cnt == dbg_pkg::rst_cnt_t'(dbg_pkg::reset_pulse_len - 1)) begin
						cpu_rst <= 1'b1;
						state   <= dbg_pkg::seq_reply;
					end else begin
						rst_cnt <= rst_cnt + 1'b1;
					end
				end
				dbg_pkg::seq_reply: begin
					// Stall on a full queue
					if (!tx_full) begin
						if (read_reply && !data_phase) begin
							data_phase <= 1'b1;
						end else begin
							data_phase <= 1'b0;
							read_reply <= 1'b0;
							state      <= dbg_pkg::seq_idle;
						end
					end
				end
				default: state <= dbg_pkg::seq_idle;
			endcase
		end
	end

	// Command fields and read data
	always_ff @(posedge clk) begin
		if (state == dbg_pkg::seq_idle && rx_valid)
			write_q <= (rx_byte == dbg_pkg::cmd_write_byte);
		if (state == dbg_pkg::seq_addr_hi && rx_valid)
			addr_q[15:8] <= rx_byte;
		if (state == dbg_pkg::seq_addr_lo && rx_valid)
			addr_q[7:0] <= rx_byte;
		if (state == dbg_pkg::seq_wdata && rx_valid)
			wdata_q <= rx_byte;
		if (bus_done)
			rdata_q <= bus_rdata;
	end

	// Safety is decided a cycle early, so the CPU must still be safe at issue
	a_req_granted: assert property (@(posedge clk) disable iff (!rst) bus_req |-> bus_grant);

endmodule

/* rtl/dbg_link_top.sv */
`timescale 1ns/1ps

module dbg_link_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               uart_rx_pin,
	output logic               uart_tx_pin,
	output logic               cpu_halt,
	output logic               cpu_rst,
	input  logic               cpu_is_halted,
	output logic               bus_grant,
	output dbg_pkg::addr_t     pc_reset,
	output dbg_pkg::addr_t     awaddr,
	output logic               awvalid,
	input  logic               awready,
	output dbg_pkg::axi_data_t wdata,
	output dbg_pkg::axi_strb_t wstrb,
	output logic               wvalid,
	input  logic               wready,
	input  dbg_pkg::axi_resp_t bresp,
	input  logic               bvalid,
	output logic               bready,
	output dbg_pkg::addr_t     araddr,
	output logic               arvalid,
	input  logic               arready,
	input  dbg_pkg::axi_data_t rdata,
	input  dbg_pkg::axi_resp_t rresp,
	input  logic               rvalid,
	output logic               rready
);

	// Receiver to sequencer
	logic rx_valid;
	uart_pkg::byte_t rx_byte;
	// Sequencer to transmitter
	logic tx_push;
	logic tx_full;
	uart_pkg::byte_t tx_byte;
	// Sequencer to bus master
	logic bus_req;
	logic bus_write;
	logic bus_done;
	logic bus_err;
	dbg_pkg::addr_t bus_addr;
	uart_pkg::byte_t bus_wdata;
	uart_pkg::byte_t bus_rdata;

	uart_rx rx_i (
		.clk         (clk),
		.rst         (rst),
		.uart_rx_pin (uart_rx_pin),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte)
	);

	dbg_cmd_seq seq_i (
		.clk           (clk),
		.rst           (rst),
		.rx_valid      (rx_valid),
		.rx_byte       (rx_byte),
		.tx_push       (tx_push),
		.tx_byte       (tx_byte),
		.tx_full       (tx_full),
		.bus_req       (bus_req),
		.bus_write     (bus_write),
		.bus_addr      (bus_addr),
		.bus_wdata     (bus_wdata),
		.bus_done      (bus_done),
		.bus_err       (bus_err),
		.bus_rdata     (bus_rdata),
		.cpu_halt      (cpu_halt),
		.cpu_rst       (cpu_rst),
		.cpu_is_halted (cpu_is_halted),
		.bus_grant     (bus_grant),
		.pc_reset      (pc_reset)
	);

	axil_byte_master axil_i (
		.clk       (clk),
		.rst       (rst),
		.bus_req   (bus_req),
		.bus_write (bus_write),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_done  (bus_done),
		.bus_err   (bus_err),
		.bus_rdata (bus_rdata),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready)
	);

	uart_tx tx_i (
		.clk         (clk),
		.rst         (rst),
		.tx_push     (tx_push),
		.tx_byte     (tx_byte),
		.tx_full     (tx_full),
		.uart_tx_pin (uart_tx_pin)
	);

endmodule

/* rtl/dbg_pkg.sv */
package dbg_pkg;

	// CPU address space and AXI4-Lite widths
	typedef logic [15:0] addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0] axi_strb_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t resp_okay = 2'b00;

	// Command bytes from the host
	typedef enum logic [7:0] {
		cmd_halt          = 8'h00,
		cmd_resume        = 8'h01,
		cmd_write_byte    = 8'h02,
		cmd_read_byte     = 8'h03,
		cmd_pulse_reset   = 8'h04,
		cmd_ping          = 8'h05,
		cmd_hold_reset    = 8'h06,
		cmd_release_reset = 8'h07
	} cmd_code_t;

	// Reply status bytes
	localparam uart_pkg::byte_t ack_code = 8'h00;
	localparam uart_pkg::byte_t nak_code = 8'hFF;

	// Length of the CPU reset pulse in clocks
	localparam int reset_pulse_len = 256;
	typedef logic [$clog2(reset_pulse_len)-1:0] rst_cnt_t;

	// Reset vector bytes, low then high
	localparam addr_t vec_lo_addr = 16'hFFFC;
	localparam addr_t vec_hi_addr = 16'hFFFD;

	// Command sequencer states
	typedef enum logic [2:0] {
		seq_idle,
		seq_addr_hi,
		seq_addr_lo,
		seq_wdata,
		seq_bus_wait,
		seq_rst_count,
		seq_reply
	} seq_state_t;

endpackage

/* rtl/uart_pkg.sv */
package uart_pkg;

	// Serial bit period in clocks, short for simulation
	localparam int clks_per_bit = 8;
	localparam int baud_cnt_w = $clog2(clks_per_bit);

	// Start bit, eight data bits, stop bit
	localparam int frame_bits = 10;

	typedef logic [7:0] byte_t;
	typedef logic [baud_cnt_w-1:0] baud_cnt_t;

	// Last count of a full bit period
	localparam baud_cnt_t baud_last = baud_cnt_t'(clks_per_bit - 1);
	// Last count of half a bit period, used to find the middle of the start bit
	localparam baud_cnt_t half_last = baud_cnt_t'(clks_per_bit / 2 - 1);

endpackage

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
	input  logic            clk,
	input  logic            rst,
	input  logic            uart_rx_pin,
	output logic            rx_valid,
	output uart_pkg::byte_t rx_byte
);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic sample_bit;
	logic [2:0] bit_idx;
	uart_pkg::baud_cnt_t baud_cnt;
	uart_pkg::byte_t shift_q;

	// Two flops against metastability, idle level is high
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx_pin;
			rx_sync <= rx_meta;
		end
	end

	// Middle of a data bit
	assign sample_bit = (state == rx_data) && (baud_cnt == uart_pkg::baud_last);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= rx_idle;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				rx_idle: begin
					baud_cnt <= '0;
					bit_idx  <= '0;
					// Falling edge marks a start bit
					if (!rx_sync)
						state <= rx_start;
				end
				rx_start: begin
					if (baud_cnt == uart_pkg::half_last) begin
						baud_cnt <= '0;
						// Glitch shorter than half a bit goes back to idle
						state <= rx_sync ? rx_idle : rx_data;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (baud_cnt == uart_pkg::baud_last) begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (baud_cnt == uart_pkg::baud_last) begin
						baud_cnt <= '0;
						// Frame only counts with a high stop bit
						rx_valid <= rx_sync;
						state    <= rx_idle;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// LSB arrives first so shift in from the top
	always_ff @(posedge clk) begin
		if (sample_bit)
			shift_q <= {rx_sync, shift_q[7:1]};
	end

	assign rx_byte = shift_q;

	// One strobe per frame
	a_rx_single: assert property (@(posedge clk) disable iff (!rst) rx_valid |=> !rx_valid);

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
	input  logic            clk,
	input  logic            rst,
	input  logic            tx_push,
	input  uart_pkg::byte_t tx_byte,
	output logic            tx_full,
	output logic            uart_tx_pin
);

	uart_pkg::byte_t q_mem [2];
	uart_pkg::byte_t load_byte;
	uart_pkg::baud_cnt_t baud_cnt;
	logic [1:0] count;
	logic wr_ptr;
	logic rd_ptr;
	logic [3:0] bits_left;
	logic [uart_pkg::frame_bits-1:0] shift_q;
	logic busy;
	logic load;
	logic pop;
	logic enq;

	assign tx_full = (count == 2'd2);
	assign busy    = (bits_left != '0);

	// Idle serializer takes the queue head, or the pushed byte directly if empty
	assign load      = !busy && (count != 2'd0 || tx_push);
	assign pop       = load && (count != 2'd0);
	assign enq       = tx_push && !tx_full && !(load && count == 2'd0);
	assign load_byte = (count != 2'd0) ? q_mem[rd_ptr] : tx_byte;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count     <= '0;
			wr_ptr    <= 1'b0;
			rd_ptr    <= 1'b0;
			bits_left <= '0;
			baud_cnt  <= '0;
			shift_q   <= '1;
		end else begin
			count <= count + {1'b0, enq} - {1'b0, pop};
			if (enq)
				wr_ptr <= !wr_ptr;
			if (pop)
				rd_ptr <= !rd_ptr;
			if (load) begin
				// Stop bit, data LSB first, start bit
				shift_q   <= {1'b1, load_byte, 1'b0};
				bits_left <= 4'(uart_pkg::frame_bits);
				baud_cnt  <= '0;
			end else if (busy) begin
				if (baud_cnt == uart_pkg::baud_last) begin
					baud_cnt  <= '0;
					shift_q   <= {1'b1, shift_q[uart_pkg::frame_bits-1:1]};
					bits_left <= bits_left - 1'b1;
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (enq)
			q_mem[wr_ptr] <= tx_byte;
	end

	// Ones shift in behind the frame so the line rests high
	assign uart_tx_pin = shift_q[0];

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_top -f tb.f -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

/* sim/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
	input logic           clk,
	input logic           rst,
	input logic           uart_tx_pin,
	input logic           cpu_halt,
	input logic           cpu_rst,
	input logic           bus_grant,
	input dbg_pkg::addr_t pc_reset
);

	// Reply bytes still owed by the DUT, oldest first
	uart_pkg::byte_t exp_q [$];
	int err_count = 0;
	int test_count = 0;
	int test_fail = 0;
	int test_err_base = 0;
	// Length of the last low period of cpu_rst
	int rst_low_len = 0;
	int rst_low_run = 0;

	task automatic expect_byte(input uart_pkg::byte_t b);
		exp_q.push_back(b);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic flush();
		exp_q.delete();
	endtask

	task automatic note_error(input string msg);
		$display("%0d ns: %s", $time, msg);
		err_count++;
	endtask

	task automatic compare(input string name, input logic [31:0] want, input logic [31:0] got);
		if (want !== got) begin
			$display("FAIL %0d ns %s expected 0x%0h got 0x%0h", $time, name, want, got);
			err_count++;
		end
	endtask

	// CPU control lines against the expected state
	task automatic check_ctrl(input logic exp_halt, input logic exp_rst,
		input dbg_pkg::addr_t exp_pc);
		compare("cpu_halt", 32'(exp_halt), 32'(cpu_halt));
		compare("cpu_rst", 32'(exp_rst), 32'(cpu_rst));
		compare("pc_reset", 32'(exp_pc), 32'(pc_reset));
		// Halt is confirmed long before the reply ends, so only halt or reset count here
		compare("bus_grant", 32'(exp_halt || !exp_rst), 32'(bus_grant));
	endtask

	task automatic start_test();
		test_err_base = err_count;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (err_count != test_err_base) begin
			test_fail++;
			$display("test %s done with %0d errors", name, err_count - test_err_base);
		end else begin
			$display("test %s done, ok", name);
		end
	endtask

	task automatic close_report();
		$display("tests run %0d, tests failed %0d, check errors %0d",
			test_count, test_fail, err_count);
	endtask

	// Middle of each bit, counted from the first low sample of the start bit
	task automatic receive_frame();
		uart_pkg::byte_t got;
		uart_pkg::byte_t want;
		int i;
		repeat (uart_pkg::clks_per_bit / 2 - 1) @(posedge clk);
		for (i = 0; i < 8; i++) begin
			repeat (uart_pkg::clks_per_bit) @(posedge clk);
			got[i] = uart_tx_pin;
		end
		repeat (uart_pkg::clks_per_bit) @(posedge clk);
		if (!uart_tx_pin)
			note_error("reply frame ended with a low stop bit");
		if (exp_q.size() == 0) begin
			note_error($sformatf("reply byte 0x%02h arrived while no reply was expected", got));
		end else begin
			want = exp_q.pop_front();
			compare("uart_tx_pin byte", 32'(want), 32'(got));
		end
	endtask

	// Serial reply decoder
	always begin
		@(posedge clk);
		if (rst && !uart_tx_pin)
			receive_frame();
	end

	// Run length of cpu_rst low, stored when it rises
	always @(posedge clk) begin
		if (!cpu_rst) begin
			rst_low_run = rst_low_run + 1;
		end else if (rst_low_run != 0) begin
			rst_low_len = rst_low_run;
			rst_low_run = 0;
		end
	end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// Free running clock with a 4 ns period
	initial clk = 1'b0;

	always #2 clk = ~clk;

endmodule

/* sim/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

	localparam int n_rw      = 64;
	localparam int n_unsafe  = 4;
	localparam int n_hold    = 4;
	localparam int n_unknown = 8;
	// Commands per test, in run order
	localparam int n_cmds = 1 + (2 + 2 * n_rw) + n_unsafe + (5 + 2 * n_hold) + 7 + (n_unknown + 1);
	localparam int clk_ns = 4;
	localparam int bit_ns = uart_pkg::clks_per_bit * clk_ns;
	// A write is five frames, so each command gets room for eight
	localparam int cmd_budget_bits = 80;
	localparam longint watchdog_ns = longint'(n_cmds) * cmd_budget_bits * bit_ns + 2000 * clk_ns;
	localparam int reply_limit = dbg_pkg::reset_pulse_len + 30 * uart_pkg::clks_per_bit;

	logic clk;
	logic rst;
	logic uart_rx_pin;
	logic uart_tx_pin;
	logic cpu_halt;
	logic cpu_rst;
	logic cpu_is_halted;
	logic bus_grant;
	dbg_pkg::addr_t pc_reset;
	dbg_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;
	dbg_pkg::axi_data_t wdata;
	dbg_pkg::axi_strb_t wstrb;
	logic wvalid;
	logic wready;
	dbg_pkg::axi_resp_t bresp;
	logic bvalid;
	logic bready;
	dbg_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	dbg_pkg::axi_data_t rdata;
	dbg_pkg::axi_resp_t rresp;
	logic rvalid;
	logic rready;

	// Memory seen over AXI, and the bytes the host expects to read back
	logic [7:0] mem [65536];
	logic [7:0] ref_mem [65536];
	int axi_count;
	logic [15:0] lfsr_q;
	// Host record of CPU control
	logic exp_halt;
	logic exp_held;
	dbg_pkg::addr_t exp_pc;

	tb_clock clk_i (
		.clk (clk)
	);

	dbg_link_top dut_i (
		.clk           (clk),
		.rst           (rst),
		.uart_rx_pin   (uart_rx_pin),
		.uart_tx_pin   (uart_tx_pin),
		.cpu_halt      (cpu_halt),
		.cpu_rst       (cpu_rst),
		.cpu_is_halted (cpu_is_halted),
		.bus_grant     (bus_grant),
		.pc_reset      (pc_reset),
		.awaddr        (awaddr),
		.awvalid       (awvalid),
		.awready       (awready),
		.wdata         (wdata),
		.wstrb         (wstrb),
		.wvalid        (wvalid),
		.wready        (wready),
		.bresp         (bresp),
		.bvalid        (bvalid),
		.bready        (bready),
		.araddr        (araddr),
		.arvalid       (arvalid),
		.arready       (arready),
		.rdata         (rdata),
		.rresp         (rresp),
		.rvalid        (rvalid),
		.rready        (rready)
	);

	tb_checker chk_i (
		.clk         (clk),
		.rst         (rst),
		.uart_tx_pin (uart_tx_pin),
		.cpu_halt    (cpu_halt),
		.cpu_rst     (cpu_rst),
		.bus_grant   (bus_grant),
		.pc_reset    (pc_reset)
	);

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [15:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	// Start contents mix every address bit
	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
	endfunction

	// SLVERR window
	function automatic logic is_err_addr(input logic [15:0] a);
		return a[15:12] == 4'hE;
	endfunction

	// Ends 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// 8N1 frame, LSB first
	task automatic send_byte(input uart_pkg::byte_t b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			uart_rx_pin = frame[i];
			idle_cycles(uart_pkg::clks_per_bit);
		end
	endtask

	task automatic wait_reply(input string what);
		int t;
		t = 0;
		while (chk_i.pending() != 0 && t < reply_limit) begin
			idle_cycles(1);
			t++;
		end
		if (chk_i.pending() != 0) begin
			chk_i.note_error($sformatf("no reply to %s within %0d clocks", what, reply_limit));
			chk_i.flush();
		end
	endtask

	task automatic rand_addr(output dbg_pkg::addr_t a);
		logic [15:0] r;
		rand_bits(16, r);
		// Move out of the error window
		if (is_err_addr(r))
			r = r ^ 16'h2000;
		a = r;
	endtask

	task automatic run_write(input dbg_pkg::addr_t a, input uart_pkg::byte_t d);
		if ((exp_halt || exp_held) && !is_err_addr(a)) begin
			chk_i.expect_byte(dbg_pkg::ack_code);
			ref_mem[a] = d;
			if (a == dbg_pkg::vec_lo_addr)
				exp_pc[7:0] = d;
			if (a == dbg_pkg::vec_hi_addr)
				exp_pc[15:8] = d;
		end else begin
			chk_i.expect_byte(dbg_pkg::nak_code);
		end
		send_byte(dbg_pkg::cmd_write_byte);
		send_byte(a[15:8]);
		send_byte(a[7:0]);
		send_byte(d);
		wait_reply("write byte");
	endtask

	task automatic run_read(input dbg_pkg::addr_t a);
		if ((exp_halt || exp_held) && !is_err_addr(a)) begin
			chk_i.expect_byte(dbg_pkg::ack_code);
			chk_i.expect_byte(ref_mem[a]);
		end else begin
			chk_i.expect_byte(dbg_pkg::nak_code);
		end
		send_byte(dbg_pkg::cmd_read_byte);
		send_byte(a[15:8]);
		send_byte(a[7:0]);
		wait_reply("read byte");
	endtask

	// Single-byte commands, always acked
	task automatic run_simple(input dbg_pkg::cmd_code_t cmd);
		case (cmd)
			dbg_pkg::cmd_halt: exp_halt = 1'b1;
			dbg_pkg::cmd_resume: exp_halt = 1'b0;
			dbg_pkg::cmd_hold_reset: exp_held = 1'b1;
			dbg_pkg::cmd_release_reset, dbg_pkg::cmd_pulse_reset: exp_held = 1'b0;
			default: ;
		endcase
		chk_i.expect_byte(dbg_pkg::ack_code);
		send_byte(cmd);
		wait_reply(cmd.name());
		chk_i.check_ctrl(exp_halt, !exp_held, exp_pc);
	endtask

	// CPU halt acknowledge, 1 to 4 cycles late
	initial begin : cpu_model
		logic [15:0] d;
		forever begin
			@(posedge clk);
			#1;
			if (!cpu_halt) begin
				cpu_is_halted = 1'b0;
			end else if (!cpu_is_halted) begin
				rand_bits(2, d);
				idle_cycles(int'(d) + 1);
				cpu_is_halted = 1'b1;
			end
		end
	end

	// AXI4-Lite memory with random ready delays of 0 to 3 cycles
	initial begin : axi_slave
		logic [15:0] d;
		logic [15:0] a;
		logic [31:0] wd;
		logic [3:0] ws;
		int i;
		forever begin
			@(posedge clk);
			#1;
			if (awvalid && wvalid) begin
				rand_bits(2, d);
				idle_cycles(int'(d));
				awready = 1'b1;
				wready  = 1'b1;
				idle_cycles(1);
				awready = 1'b0;
				wready  = 1'b0;
				a  = awaddr;
				wd = wdata;
				ws = wstrb;
				axi_count++;
				// Rejected writes leave memory alone
				if (!is_err_addr(a)) begin
					for (i = 0; i < 4; i++) begin
						if (ws[i])
							mem[{a[15:2], i[1:0]}] = wd[8*i +: 8];
					end
				end
				rand_bits(2, d);
				idle_cycles(int'(d));
				bresp  = is_err_addr(a) ? 2'b10 : 2'b00;
				bvalid = 1'b1;
				while (!bready)
					idle_cycles(1);
				idle_cycles(1);
				bvalid = 1'b0;
			end else if (arvalid) begin
				rand_bits(2, d);
				idle_cycles(int'(d));
				arready = 1'b1;
				idle_cycles(1);
				arready = 1'b0;
				a = araddr;
				axi_count++;
				rand_bits(2, d);
				idle_cycles(int'(d));
				rdata = {mem[{a[15:2], 2'd3}], mem[{a[15:2], 2'd2}],
				         mem[{a[15:2], 2'd1}], mem[{a[15:2], 2'd0}]};
				rresp  = is_err_addr(a) ? 2'b10 : 2'b00;
				rvalid = 1'b1;
				while (!rready)
					idle_cycles(1);
				idle_cycles(1);
				rvalid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("watchdog ended the run after %0d ns", watchdog_ns);
		$display("Test failed");
		$finish;
	end

	initial begin : stimulus
		dbg_pkg::addr_t addrs [n_rw];
		dbg_pkg::addr_t a;
		logic [15:0] r;
		int base;
		int i;
		rst           = 1'b0;
		uart_rx_pin   = 1'b1;
		cpu_is_halted = 1'b0;
		awready       = 1'b0;
		wready        = 1'b0;
		bresp         = 2'b00;
		bvalid        = 1'b0;
		arready       = 1'b0;
		rdata         = '0;
		rresp         = 2'b00;
		rvalid        = 1'b0;
		lfsr_q        = 16'd3783;
		axi_count     = 0;
		exp_halt      = 1'b0;
		exp_held      = 1'b0;
		exp_pc        = '0;
		for (i = 0; i < 65536; i++) begin
			mem[i]     = fill_byte(16'(i));
			ref_mem[i] = mem[i];
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b1;
		idle_cycles(4);

		chk_i.start_test();
		run_simple(dbg_pkg::cmd_ping);
		chk_i.finish_test("ping");

		// Halted CPU, random writes then read back
		chk_i.start_test();
		run_simple(dbg_pkg::cmd_halt);
		for (i = 0; i < n_rw; i++) begin
			rand_addr(addrs[i]);
			rand_bits(8, r);
			run_write(addrs[i], r[7:0]);
		end
		for (i = 0; i < n_rw; i++)
			run_read(addrs[i]);
		run_simple(dbg_pkg::cmd_resume);
		chk_i.finish_test("halted access");

		// Running CPU, no access may reach the bus
		chk_i.start_test();
		base = axi_count;
		for (i = 0; i < n_unsafe; i++) begin
			rand_addr(a);
			rand_bits(1, r);
			if (r[0]) begin
				rand_bits(8, r);
				run_write(a, r[7:0]);
			end else begin
				run_read(a);
			end
		end
		chk_i.compare("axi transaction count", 32'(base), 32'(axi_count));
		chk_i.finish_test("running cpu");

		// Held in reset, released, then pulsed
		chk_i.start_test();
		run_simple(dbg_pkg::cmd_hold_reset);
		for (i = 0; i < n_hold; i++) begin
			rand_addr(addrs[i]);
			rand_bits(8, r);
			run_write(addrs[i], r[7:0]);
		end
		for (i = 0; i < n_hold; i++)
			run_read(addrs[i]);
		run_simple(dbg_pkg::cmd_release_reset);
		rand_addr(a);
		rand_bits(8, r);
		run_write(a, r[7:0]);
		run_read(a);
		run_simple(dbg_pkg::cmd_pulse_reset);
		chk_i.compare("cpu_rst low clocks", 32'(dbg_pkg::reset_pulse_len),
			32'(chk_i.rst_low_len));
		chk_i.finish_test("reset control");

		// Reset vector capture and the error window
		chk_i.start_test();
		run_simple(dbg_pkg::cmd_halt);
		rand_bits(8, r);
		run_write(dbg_pkg::vec_lo_addr, r[7:0]);
		rand_bits(8, r);
		run_write(dbg_pkg::vec_hi_addr, r[7:0]);
		chk_i.check_ctrl(exp_halt, !exp_held, exp_pc);
		rand_addr(a);
		// Stay off the vector bytes
		if (a[15:2] == 14'h3FFF)
			a[4] = ~a[4];
		rand_bits(8, r);
		run_write(a, r[7:0]);
		chk_i.check_ctrl(exp_halt, !exp_held, exp_pc);
		rand_bits(12, r);
		a = {4'hE, r[11:0]};
		rand_bits(8, r);
		run_write(a, r[7:0]);
		run_read(a);
		chk_i.check_ctrl(exp_halt, !exp_held, exp_pc);
		run_simple(dbg_pkg::cmd_resume);
		chk_i.finish_test("reset vector");

		// Unknown bytes, long gap so a stray reply is fully decoded
		chk_i.start_test();
		for (i = 0; i < n_unknown; i++) begin
			rand_bits(8, r);
			if (r[7:0] < 8'h08)
				r[3] = 1'b1;
			send_byte(r[7:0]);
			idle_cycles(12 * uart_pkg::clks_per_bit);
		end
		chk_i.check_ctrl(exp_halt, !exp_held, exp_pc);
		run_simple(dbg_pkg::cmd_ping);
		chk_i.finish_test("unknown bytes");

		chk_i.close_report();
		if (chk_i.err_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tb.f */
rtl/uart_pkg.sv
rtl/dbg_pkg.sv
rtl/uart_rx.sv
rtl/dbg_cmd_seq.sv
rtl/axil_byte_master.sv
rtl/uart_tx.sv
rtl/dbg_link_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv
